/* hw/vic_pkg.sv */
`default_nettype none

package vic_pkg;

    // ------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------

    localparam int NUM_SPRITES = 8;

    // raster x counts pixels, one per four dot4x ticks
    localparam int XPOS_W = 10;
    localparam int LINE_W = 9;

    // eight pixels per cycle, so cycle is raster_x without its low 3 bits
    localparam int CYCLE_W = 7;

    // sprite ba windows, measured on sprite_raster_x
    localparam int SPRITE_BA_STEP = 16;
    // 3 cycles of warning plus the p/s accesses
    localparam int SPRITE_BA_LEN = 40;

    // lines on which a badline may happen
    localparam int BADLINE_FIRST = 48;
    localparam int BADLINE_LAST = 248;

    // ------------------------------------------------------------
    // chip models
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6569     = 2'd1,
        CHIP_6567R56A = 2'd2,
        // behaves as a 6569
        CHIP_UNUSED   = 2'd3
    } chip_t;

    typedef struct packed {
        logic [XPOS_W-1:0]  raster_x_max;
        logic [LINE_W-1:0]  raster_y_max;
        // cycle whose low phase decides sprite dma
        logic [CYCLE_W-1:0] sprite_dmachk;
        // character ba window, wraps through raster_x 0
        logic [XPOS_W-1:0]  chars_ba_start;
        logic [XPOS_W-1:0]  chars_ba_end;
        // raster_x where sprite 0 drops ba
        logic [XPOS_W-1:0]  sprite_ba_origin;
    } chip_limits_t;

    function automatic chip_limits_t chip_limits(input chip_t chip);
        chip_limits_t lim;
        lim.chars_ba_end = 10'h14c;
        case (chip)
            CHIP_6567R8: begin
                // 520 pixels, 263 lines
                lim.raster_x_max     = 10'd519;
                lim.raster_y_max     = 9'd262;
                lim.sprite_dmachk    = 7'd55;
                lim.chars_ba_start   = 10'h1f4;
                lim.sprite_ba_origin = 10'd448;
            end
            CHIP_6567R56A: begin
                // 512 pixels, 262 lines
                lim.raster_x_max     = 10'd511;
                lim.raster_y_max     = 9'd261;
                lim.sprite_dmachk    = 7'd55;
                lim.chars_ba_start   = 10'h1f4;
                lim.sprite_ba_origin = 10'd448;
            end
            default: begin
                // 6569 pal, 504 pixels, 312 lines
                lim.raster_x_max     = 10'd503;
                lim.raster_y_max     = 9'd311;
                lim.sprite_dmachk    = 7'd54;
                lim.chars_ba_start   = 10'h1ec;
                lim.sprite_ba_origin = 10'd440;
            end
        endcase
        return lim;
    endfunction

    // ------------------------------------------------------------
    // bundles between blocks
    // ------------------------------------------------------------

    typedef struct packed {
        logic        phi;
        // [0] is the last tick of a pixel
        logic [3:0]  dot_rising;
        // [15] means phi toggles on the next tick
        logic [15:0] phase_start;
    } phase_t;

    typedef struct packed {
        logic [XPOS_W-1:0]  raster_x;
        logic [LINE_W-1:0]  raster_line;
        logic [LINE_W-1:0]  raster_line_d;
        logic [CYCLE_W-1:0] cycle_num;
        logic [XPOS_W-1:0]  sprite_raster_x;
    } raster_pos_t;

    typedef struct packed {
        logic                             den;
        logic [2:0]                       yscroll;
        logic [LINE_W-1:0]                irq_compare;
        logic                             erst;
        logic [NUM_SPRITES-1:0]           sprite_en;
        logic [NUM_SPRITES-1:0][7:0]      sprite_y;
    } vic_cfg_t;

endpackage

`default_nettype wire

/* hw/phase_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_gen import vic_pkg::*; (
    input  logic   clk_dot4x,
    input  logic   rst,
    output phase_t phase_o
);

    // phi pattern, 16 low and 16 high, bit 0 is the level
    logic [31:0] phi_sr;
    // one-hot position inside the current half phase
    logic [15:0] phase_sr;
    // one-hot position inside a pixel
    logic [3:0]  dot_sr;

    // reset values are skewed on purpose
    // raster (0,0) is then shared by all chip models, phi starts
    // low but partway through its low phase
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phi_sr   <= 32'b0000_0000_0000_1111_1111_1111_1111_0000;
            phase_sr <= 16'b0000_0000_0000_1000;
            dot_sr   <= 4'b1000;
        end else begin
            phi_sr   <= {phi_sr[30:0], phi_sr[31]};
            phase_sr <= {phase_sr[14:0], phase_sr[15]};
            dot_sr   <= {dot_sr[2:0], dot_sr[3]};
        end
    end

    assign phase_o = '{
        phi:         phi_sr[0],
        dot_rising:  dot_sr,
        phase_start: phase_sr
    };

endmodule

`default_nettype wire

/* hw/raster_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_counter import vic_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  chip_t       chip_i,
    input  phase_t      phase_i,
    output raster_pos_t pos_o
);

    chip_limits_t lim;

    logic [XPOS_W-1:0] raster_x;
    logic [LINE_W-1:0] raster_line;
    logic [LINE_W-1:0] raster_line_d;
    logic [XPOS_W-1:0] line_len;
    logic [XPOS_W-1:0] sprite_raster_x;

    // chip only changes under reset, so the table is static in use
    assign lim = chip_limits(chip_i);
    assign line_len = lim.raster_x_max + 1'b1;

    // ------------------------------------------------------------
    // pixel and line counters
    // ------------------------------------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x      <= '0;
            raster_line   <= '0;
            raster_line_d <= '0;
        end else begin
            // one step per pixel
            if (phase_i.dot_rising[0]) begin
                if (raster_x == lim.raster_x_max) begin
                    raster_x <= '0;
                    if (raster_line == lim.raster_y_max) begin
                        raster_line <= '0;
                    end else begin
                        raster_line <= raster_line + 1'b1;
                    end
                end else begin
                    raster_x <= raster_x + 1'b1;
                end
            end
            // readers sampling at the same tick still see the old line
            if (!phase_i.phi && phase_i.phase_start[1]) begin
                raster_line_d <= raster_line;
            end
        end
    end

    // shift x so sprite 0 drops ba at 0
    // sprite windows then never straddle the line wrap
    always_comb begin
        if (raster_x >= lim.sprite_ba_origin) begin
            sprite_raster_x = raster_x - lim.sprite_ba_origin;
        end else begin
            sprite_raster_x = raster_x + line_len - lim.sprite_ba_origin;
        end
    end

    assign pos_o = '{
        raster_x:        raster_x,
        raster_line:     raster_line,
        raster_line_d:   raster_line_d,
        // valid from phase_start[1] of the low phase
        cycle_num:       raster_x[XPOS_W-1:3],
        sprite_raster_x: sprite_raster_x
    };

endmodule

`default_nettype wire

/* hw/sprite_dma_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_dma_slot import vic_pkg::*; #(
    parameter int SPRITE_IDX = 0
) (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  chip_t       chip_i,
    input  phase_t      phase_i,
    input  raster_pos_t pos_i,
    input  logic        sprite_en_i,
    input  logic [7:0]  sprite_y_i,
    output logic        ba_req_o
);

    // this sprite's window on sprite_raster_x
    localparam logic [XPOS_W-1:0] BA_START = XPOS_W'(SPRITE_IDX * SPRITE_BA_STEP);
    localparam logic [XPOS_W-1:0] BA_END = XPOS_W'(SPRITE_IDX * SPRITE_BA_STEP + SPRITE_BA_LEN);

    chip_limits_t lim;
    logic         dma_check;
    logic         y_match;
    logic         dma;

    assign lim = chip_limits(chip_i);

    // check point is the start of the dmachk cycle, low phase
    assign dma_check = !phase_i.phi && phase_i.phase_start[1]
                       && pos_i.cycle_num == lim.sprite_dmachk;
    // only the low byte of the line is compared
    assign y_match = sprite_en_i && sprite_y_i == pos_i.raster_line[7:0];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dma <= 1'b0;
        end else if (dma_check && y_match) begin
            dma <= 1'b1;
        end else if (pos_i.sprite_raster_x == BA_END) begin
            // window has passed
            dma <= 1'b0;
        end
    end

    // request ba low over the window
    assign ba_req_o = dma && pos_i.sprite_raster_x >= BA_START
                      && pos_i.sprite_raster_x < BA_END;

endmodule

`default_nettype wire

/* hw/badline_detect.sv */
`timescale 1ns/1ps
`default_nettype none

module badline_detect import vic_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  chip_t       chip_i,
    input  phase_t      phase_i,
    input  raster_pos_t pos_i,
    input  logic        den_i,
    input  logic [2:0]  yscroll_i,
    output logic        chars_ba_req_o
);

    chip_limits_t lim;
    logic         eval;
    logic         allow_bad_lines;
    logic         allow_next;
    logic         badline;

    assign lim = chip_limits(chip_i);

    // once per cycle, start of phi low
    assign eval = !phase_i.phi && phase_i.phase_start[1];

    // den counts anywhere on line 48
    // raster_line_d still holds 48 at cycle 0 of line 49, which
    // catches den written in the last cycle of 48
    always_comb begin
        allow_next = allow_bad_lines;
        if (den_i && ((pos_i.raster_line == BADLINE_FIRST && pos_i.cycle_num == '0)
                      || pos_i.raster_line_d == BADLINE_FIRST)) begin
            allow_next = 1'b1;
        end
        if (pos_i.raster_line == BADLINE_LAST) begin
            allow_next = 1'b0;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline         <= 1'b0;
        end else if (eval) begin
            allow_bad_lines <= allow_next;
            badline <= allow_next && pos_i.raster_line[2:0] == yscroll_i
                       && pos_i.raster_line >= BADLINE_FIRST
                       && pos_i.raster_line < BADLINE_LAST;
        end
    end

    // active low, window wraps through raster_x 0
    assign chars_ba_req_o = !(badline && (pos_i.raster_x >= lim.chars_ba_start
                                          || pos_i.raster_x < lim.chars_ba_end));

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import vic_pkg::*; (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    input  phase_t                 phase_i,
    // active low, from badline_detect
    input  logic                   chars_ba_req_i,
    // active high, one bit per sprite
    input  logic [NUM_SPRITES-1:0] sprite_ba_req_i,
    output logic                   ba_o,
    output logic                   aec_o,
    output logic                   vic_write_ab_o
);

    logic       ba_next;
    logic       hist_sample;
    logic       ba1;
    logic       ba2;
    logic       ba3;
    logic [1:0] aec_d;

    assign ba_next = chars_ba_req_i && sprite_ba_req_i == '0;

    // last tick of each phi high phase
    assign hist_sample = phase_i.phi && phase_i.phase_start[15];

    // ------------------------------------------------------------
    // ba, its history and aec
    // ------------------------------------------------------------

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o  <= 1'b1;
            ba1   <= 1'b1;
            ba2   <= 1'b1;
            ba3   <= 1'b1;
            aec_o <= 1'b0;
            aec_d <= '0;
        end else begin
            ba_o <= ba_next;
            // ba3 drops on the third high phase with ba low
            if (hist_sample) begin
                ba1 <= ba_o;
                ba2 <= ba1 | ba_o;
                ba3 <= ba2 | ba_o;
            end
            // cpu keeps its high phases until ba3 falls
            aec_o <= ba_o ? phase_i.phi : ba3 & phase_i.phi;
            aec_d <= {aec_d[0], aec_o};
        end
    end

    // drive the address bus a couple of ticks after aec falls,
    // release it as soon as aec rises
    assign vic_write_ab_o = !(aec_o || aec_d[1]);

endmodule

`default_nettype wire

/* hw/raster_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_irq import vic_pkg::*; (
    input  logic              clk_dot4x,
    input  logic              rst,
    input  phase_t            phase_i,
    input  raster_pos_t       pos_i,
    input  logic [LINE_W-1:0] compare_i,
    input  logic              erst_i,
    input  logic              irq_clr_i,
    output logic              irq_o
);

    logic [LINE_W-1:0] compare_d;
    // interrupt latch
    logic              irst;
    // already fired on this line
    logic              triggered;

    // compare value lags one tick, in step with raster_line_d
    always_ff @(posedge clk_dot4x) begin
        compare_d <= compare_i;
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irst      <= 1'b0;
            triggered <= 1'b0;
        end else begin
            if (pos_i.raster_line_d == compare_d) begin
                // fires even with erst clear
                if (!phase_i.phi && phase_i.phase_start[8] && !triggered) begin
                    triggered <= 1'b1;
                    irst      <= 1'b1;
                end
            end else begin
                triggered <= 1'b0;
            end
            // clear beats a trigger in the same tick
            if (irq_clr_i) begin
                irst <= 1'b0;
            end
        end
    end

    // pending latch shows up as soon as erst is set
    assign irq_o = irst & erst_i;

endmodule

`default_nettype wire

/* hw/vic_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vic_timing import vic_pkg::*; (
    input  logic              clk_dot4x,
    input  logic              rst,
    input  chip_t             chip_i,
    input  vic_cfg_t          cfg_i,
    input  logic              irq_clr_i,
    output logic              clk_phi_o,
    output logic              ba_o,
    output logic              aec_o,
    output logic              vic_write_ab_o,
    output logic              irq_o,
    output logic [XPOS_W-1:0] raster_x_o,
    output logic [LINE_W-1:0] raster_line_o
);

    phase_t                 phase;
    raster_pos_t            pos;
    logic                   chars_ba_req;
    logic [NUM_SPRITES-1:0] sprite_ba_req;

    // ------------------------------------------------------------
    // clocking and raster position
    // ------------------------------------------------------------

    phase_gen phase_gen_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase)
    );

    raster_counter raster_counter_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip_i),
        .phase_i   (phase),
        .pos_o     (pos)
    );

    // ------------------------------------------------------------
    // ba sources
    // ------------------------------------------------------------

    badline_detect badline_detect_inst (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip_i         (chip_i),
        .phase_i        (phase),
        .pos_i          (pos),
        .den_i          (cfg_i.den),
        .yscroll_i      (cfg_i.yscroll),
        .chars_ba_req_o (chars_ba_req)
    );

    for (genvar k = 0; k < NUM_SPRITES; k++) begin : gen_sprite
        sprite_dma_slot #(
            .SPRITE_IDX (k)
        ) sprite_dma_slot_inst (
            .clk_dot4x   (clk_dot4x),
            .rst         (rst),
            .chip_i      (chip_i),
            .phase_i     (phase),
            .pos_i       (pos),
            .sprite_en_i (cfg_i.sprite_en[k]),
            .sprite_y_i  (cfg_i.sprite_y[k]),
            .ba_req_o    (sprite_ba_req[k])
        );
    end

    bus_arbiter bus_arbiter_inst (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .phase_i         (phase),
        .chars_ba_req_i  (chars_ba_req),
        .sprite_ba_req_i (sprite_ba_req),
        .ba_o            (ba_o),
        .aec_o           (aec_o),
        .vic_write_ab_o  (vic_write_ab_o)
    );

    raster_irq raster_irq_inst (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .pos_i     (pos),
        .compare_i (cfg_i.irq_compare),
        .erst_i    (cfg_i.erst),
        .irq_clr_i (irq_clr_i),
        .irq_o     (irq_o)
    );

    assign clk_phi_o = phase.phi;
    assign raster_x_o = pos.raster_x;
    // the register view of the line is the delayed one
    assign raster_line_o = pos.raster_line_d;

endmodule

`default_nettype wire

/* verif/vic_timing_tb_tasks.svh */
`ifndef VIC_TIMING_TB_TASKS_SVH
`define VIC_TIMING_TB_TASKS_SVH

// ------------------------------------------------------------
// reset state, phi period and aec without requests
// ------------------------------------------------------------

task automatic test_reset_phi();
    logic prev_phi;
    int   last;
    int   start_err;
    start_err = errors;
    apply_reset(CHIP_6569);
    @(negedge clk_dot4x);
    check_value("ba_o", ba_o, 1);
    check_value("irq_o", irq_o, 0);
    prev_phi = clk_phi_o;
    last = -1;
    for (int i = 0; i < 200; i++) begin
        @(negedge clk_dot4x);
        // aec is phi one tick late
        check_value("aec_o", aec_o, prev_phi);
        if (clk_phi_o != prev_phi) begin
            if (last >= 0) begin
                check_value("phi half period", i - last, 16);
            end else begin
                check_value("first phi edge is a rise", clk_phi_o, 1);
                // i counts ticks from the first clock with rst low
                check_value("ticks to first phi rise", i, 12);
            end
            last = i;
        end
        prev_phi = clk_phi_o;
    end
    tests++;
    $display("reset and phi: %0d errors", errors - start_err);
endtask

// ------------------------------------------------------------
// every pixel and line step of one full frame
// ------------------------------------------------------------

task automatic test_raster_wrap(input chip_t c, input int xmax, input int ymax);
    logic [XPOS_W-1:0] px;
    logic [LINE_W-1:0] pl;
    int                run;
    int                steps;
    bit                wrapped;
    int                start_err;
    start_err = errors;
    apply_reset(c);
    @(negedge clk_dot4x);
    px = raster_x_o;
    pl = raster_line_o;
    run = 0;
    steps = 0;
    wrapped = 1'b0;
    for (int i = 0; i < (ymax + 3) * (xmax + 1) * 4; i++) begin
        @(negedge clk_dot4x);
        run++;
        if (raster_x_o != px) begin
            check_value("raster_x_o", raster_x_o, (px == xmax) ? 0 : px + 1);
            // first pixel after reset is short
            if (steps > 0) begin
                check_value("pixel length", run, 4);
            end
            steps++;
            px = raster_x_o;
            run = 0;
        end
        if (raster_line_o != pl) begin
            check_value("raster_line_o", raster_line_o, (pl == ymax) ? 0 : pl + 1);
            // the line only steps right after x wraps
            check_value("raster_x_o at line step", raster_x_o, 0);
            if (pl == ymax) begin
                wrapped = 1'b1;
                break;
            end
            pl = raster_line_o;
        end
    end
    if (!wrapped) begin
        note_timeout("the frame wrap");
    end
    tests++;
    $display("raster wrap, chip %s: %0d errors", c.name(), errors - start_err);
endtask

// ------------------------------------------------------------
// badlines sampled mid line at x 100
// ------------------------------------------------------------

task automatic test_badlines();
    int  ys;
    bit  bad;
    int  start_err;
    start_err = errors;
    ys = {$random(seed)} % 8;
    apply_reset(CHIP_6569);
    cfg.den     <= 1'b1;
    cfg.yscroll <= ys[2:0];
    for (int line = 40; line <= 260; line++) begin
        wait_pos(line, 100, 100000);
        bad = line >= 48 && line < 248 && line % 8 == ys;
        check_value($sformatf("ba_o line %0d", line), ba_o, bad ? 0 : 1);
    end
    // no badline at all with den clear
    apply_reset(CHIP_6569);
    cfg.den <= 1'b0;
    for (int line = 44; line <= 56; line++) begin
        wait_pos(line, 100, 100000);
        check_value($sformatf("ba_o line %0d, den clear", line), ba_o, 1);
    end
    tests++;
    $display("badlines, yscroll %0d: %0d errors", ys, errors - start_err);
endtask

// ------------------------------------------------------------
// one sprite with its window counted from sprite_ba_origin
// ------------------------------------------------------------

task automatic test_sprite_dma();
    int k;
    int y;
    bit low;
    int start_err;
    start_err = errors;
    k = {$random(seed)} % 8;
    y = 100;
    apply_reset(CHIP_6569);
    cfg.sprite_en    <= 8'(1 << k);
    cfg.sprite_y[k]  <= 8'(y);
    // line before the match and then the match line
    for (int line = y - 1; line <= y; line++) begin
        // 440 is the 6569 origin
        wait_pos(line, 440, 250000);
        for (int p = 0; p < k * 16 + 44; p++) begin
            if (p > 0) begin
                next_pixel();
            end
            // ba_o lags the pixel by one tick
            @(negedge clk_dot4x);
            low = line == y && p >= k * 16 && p < k * 16 + 40;
            check_value($sformatf("ba_o line %0d pixel %0d", line, p), ba_o, low ? 0 : 1);
        end
    end
    cfg.sprite_en <= '0;
    tests++;
    $display("sprite dma, sprite %0d: %0d errors", k, errors - start_err);
endtask

// ------------------------------------------------------------
// aec held low after three phi high phases
// ------------------------------------------------------------

task automatic test_aec_steal();
    int   phase_idx;
    int   stolen;
    bit   released;
    logic prev_phi;
    int   start_err;
    start_err = errors;
    apply_reset(CHIP_6569);
    cfg.den     <= 1'b1;
    cfg.yscroll <= 3'd3;
    wait_ba(1'b0, 150000);
    // a high phase already running counts as the first
    phase_idx = clk_phi_o ? 1 : 0;
    prev_phi = clk_phi_o;
    stolen = 0;
    released = 1'b0;
    for (int i = 0; i < 4000 && !timed_out; i++) begin
        @(negedge clk_dot4x);
        if (ba_o) begin
            released = 1'b1;
            break;
        end
        if (clk_phi_o && !prev_phi) begin
            phase_idx++;
        end
        if (clk_phi_o && phase_idx > 3) begin
            check_value("aec_o stolen", aec_o, 0);
            check_value("vic_write_ab_o stolen", vic_write_ab_o, 1);
            stolen++;
        end
        prev_phi = clk_phi_o;
    end
    if (!released) begin
        note_timeout("ba_o to rise after the badline");
    end
    check_value("stolen phases seen", stolen > 0, 1);
    cfg.den <= 1'b0;
    tests++;
    $display("aec steal: %0d errors", errors - start_err);
endtask

// ------------------------------------------------------------
// raster irq latch, clear and late enable
// ------------------------------------------------------------

task automatic test_raster_irq();
    int line;
    bit seen_zero;
    bit reached;
    int start_err;
    start_err = errors;
    line = 60;
    apply_reset(CHIP_6569);
    cfg.erst        <= 1'b1;
    cfg.irq_compare <= 9'(line);
    wait_irq(1'b1, 200000);
    check_value("raster_line_o at irq",
                raster_line_o == line || raster_line_o == line + 1, 1);
    // held for half a line, then cleared while the matching line still runs
    for (int i = 0; i < 1000 && !timed_out; i++) begin
        @(negedge clk_dot4x);
        check_value("irq_o held", irq_o, 1);
    end
    @(posedge clk_dot4x);
    irq_clr <= 1'b1;
    @(posedge clk_dot4x);
    irq_clr <= 1'b0;
    @(negedge clk_dot4x);
    check_value("irq_o after clear", irq_o, 0);
    // no second trigger on this line and none up to line L of the next frame
    seen_zero = 1'b0;
    reached = 1'b0;
    for (int i = 0; i < 700000 && !timed_out; i++) begin
        @(negedge clk_dot4x);
        check_value("irq_o before next frame", irq_o, 0);
        if (raster_line_o == 0) begin
            seen_zero = 1'b1;
        end
        if (seen_zero && raster_line_o == line) begin
            reached = 1'b1;
            break;
        end
    end
    if (!reached) begin
        note_timeout("line L of the next frame");
    end
    // the latch still sets on this line while disabled
    @(posedge clk_dot4x);
    cfg.erst <= 1'b0;
    wait_pos(line + 2, -1, 10000);
    @(negedge clk_dot4x);
    check_value("irq_o with erst clear", irq_o, 0);
    @(posedge clk_dot4x);
    cfg.erst <= 1'b1;
    @(negedge clk_dot4x);
    check_value("irq_o on late enable", irq_o, 1);
    tests++;
    $display("raster irq: %0d errors", errors - start_err);
endtask

`endif

/* verif/vic_timing_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vic_timing_tb import vic_pkg::*; ();

    logic              clk_dot4x;
    logic              rst;
    chip_t             chip;
    vic_cfg_t          cfg;
    logic              irq_clr;
    logic              clk_phi_o;
    logic              ba_o;
    logic              aec_o;
    logic              vic_write_ab_o;
    logic              irq_o;
    logic [XPOS_W-1:0] raster_x_o;
    logic [LINE_W-1:0] raster_line_o;

    int seed;
    int errors;
    int checks;
    int tests;
    bit timed_out;

    vic_timing vic_timing_inst (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip_i         (chip),
        .cfg_i          (cfg),
        .irq_clr_i      (irq_clr),
        .clk_phi_o      (clk_phi_o),
        .ba_o           (ba_o),
        .aec_o          (aec_o),
        .vic_write_ab_o (vic_write_ab_o),
        .irq_o          (irq_o),
        .raster_x_o     (raster_x_o),
        .raster_line_o  (raster_line_o)
    );

    // 40 ns dot4x clock
    always #20 clk_dot4x = ~clk_dot4x;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    task automatic check_value(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    task automatic note_timeout(input string what);
        // later waits return at once, so only the first one is reported
        if (!timed_out) begin
            $display("ERROR at %0t: gave up waiting for %s", $time, what);
        end
        timed_out = 1'b1;
    endtask

    // chip changes only here, under reset
    task automatic apply_reset(input chip_t c);
        @(posedge clk_dot4x);
        rst  <= 1'b1;
        chip <= c;
        repeat (16) @(posedge clk_dot4x);
        rst <= 1'b0;
    endtask

    // polls on the falling edge, x below 0 matches any x
    task automatic wait_pos(input int line, input int x, input int limit);
        int n;
        n = 0;
        while (!timed_out && !(raster_line_o == line && (x < 0 || raster_x_o == x))) begin
            @(negedge clk_dot4x);
            n++;
            if (n > limit) begin
                note_timeout($sformatf("raster line %0d x %0d", line, x));
            end
        end
    endtask

    task automatic wait_ba(input logic level, input int limit);
        int n;
        n = 0;
        while (!timed_out && ba_o !== level) begin
            @(negedge clk_dot4x);
            n++;
            if (n > limit) begin
                note_timeout("a change of ba_o");
            end
        end
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int n;
        n = 0;
        while (!timed_out && irq_o !== level) begin
            @(negedge clk_dot4x);
            n++;
            if (n > limit) begin
                note_timeout("a change of irq_o");
            end
        end
    endtask

    // returns on the first falling edge of the next pixel
    task automatic next_pixel();
        logic [XPOS_W-1:0] x0;
        int                n;
        x0 = raster_x_o;
        n = 0;
        while (!timed_out && raster_x_o == x0) begin
            @(negedge clk_dot4x);
            n++;
            if (n > 8) begin
                note_timeout("the next pixel");
            end
        end
    endtask

    `include "vic_timing_tb_tasks.svh"

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        clk_dot4x = 1'b0;
        rst       = 1'b1;
        chip      = CHIP_6569;
        cfg       = '0;
        irq_clr   = 1'b0;
        seed      = 43;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;

        test_reset_phi();
        if (!timed_out) test_raster_wrap(CHIP_6569, 503, 311);
        if (!timed_out) test_raster_wrap(CHIP_6567R8, 519, 262);
        if (!timed_out) test_badlines();
        if (!timed_out) test_sprite_dma();
        if (!timed_out) test_aec_steal();
        if (!timed_out) test_raster_irq();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verif
hw/vic_pkg.sv
hw/phase_gen.sv
hw/raster_counter.sv
hw/sprite_dma_slot.sv
hw/badline_detect.sv
hw/bus_arbiter.sv
hw/raster_irq.sv
hw/vic_timing.sv
verif/vic_timing_tb.sv
